/* filelist.f */
+incdir+src
src/cpu_pkg.sv
src/inst_fetch.sv
src/reg_file.sv
src/exec_unit.sv
src/data_mem.sv
src/axi_lite_writer.sv
src/core_ctrl.sv
src/cpu_top.sv
test/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cpu -f filelist.f -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* src/axi_lite_writer.sv */
/*
 * Single-beat AXI4-Lite write master.
 * wr is sampled on wr_start while idle, wr_done pulses after the B handshake.
 * bresp is not looked at.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module axi_lite_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_start,
    input  cpu_pkg::mem_wr_t           wr,
    output logic                       wr_done,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [`CPU_AXI_ADDR_W-1:0] awaddr,
    output logic                       wvalid,
    input  logic                       wready,
    output cpu_pkg::word_t             wdata,
    output logic [1:0]                 wstrb,
    input  logic                       bvalid,
    output logic                       bready
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {wr_idle, wr_addr_data, wr_resp} wr_state_e;

    wr_state_e state;
    logic      aw_done, w_done;     // Per-channel handshake seen
    logic      aw_fin, w_fin;

    assign wstrb  = 2'b11;          // Full 16-bit word
    assign aw_fin = aw_done | (awvalid & awready);
    assign w_fin  = w_done | (wvalid & wready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= wr_idle;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                wr_idle: begin
                    if (wr_start) begin
                        awvalid <= 1'b1;    // AW and W raised together
                        wvalid  <= 1'b1;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= wr_addr_data;
                    end
                end
                wr_addr_data: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        aw_done <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                        w_done <= 1'b1;
                    end
                    if (aw_fin && w_fin) begin
                        bready <= 1'b1;
                        state  <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bvalid) begin       // bready is high here
                        bready  <= 1'b0;
                        wr_done <= 1'b1;
                        state   <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    // Address and data held until their handshakes
    always_ff @(posedge clk) begin
        if (state == wr_idle && wr_start) begin
            awaddr <= wr.addr;
            wdata  <= wr.data;
        end
    end

endmodule

`default_nettype wire

/* src/core_ctrl.sv */
/*
 * Sequencer, one instruction in flight.
 * ALU, branch, jump take 4 cycles, mult and load 5.
 * Store waits on the AXI write and retires the cycle after wr_done.
 * Fetch starts only while run is high.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module core_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  cpu_pkg::inst_t      inst,
    input  logic [11:0]         pc,
    input  cpu_pkg::exec_res_t  res,
    input  cpu_pkg::word_t      mem_rd,
    input  cpu_pkg::word_t      rt_val,
    output logic                fetch_en,
    output logic                rd_en,
    output logic                ex_en,
    output logic                redirect_en,
    output logic [11:0]         next_pc,
    output logic                rf_wr_en,
    output logic [3:0]          rf_wr_idx,
    output cpu_pkg::word_t      rf_wr_val,
    output logic                dm_wr_en,
    output logic [7:0]          dm_idx,
    output cpu_pkg::word_t      dm_wr_val,
    output logic                wr_start,
    output cpu_pkg::mem_wr_t    wr,
    input  logic                wr_done,
    output logic                retire_valid,
    output cpu_pkg::retire_t    retire
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        st_fetch, st_read, st_exec, st_mul, st_mem, st_wait, st_wb
    } state_e;

    state_e      state, state_nx;
    logic [11:0] inst_pc;           // PC of the instruction in flight
    logic        is_load, is_store, writes_rf;

    assign is_load   = (inst.opcode == op_load);
    assign is_store  = (inst.opcode == op_store);
    assign writes_rf = is_load || inst.opcode == op_arith || inst.opcode == op_slt_mul;

    // ########################################
    // Sequencer
    always_comb begin
        state_nx = state;
        case (state)
            st_fetch: if (run) state_nx = st_read;
            st_read:  state_nx = st_exec;
            st_exec: begin
                case (inst.opcode)
                    op_slt_mul:       state_nx = inst.func ? st_mul : st_wb;
                    op_load, op_store: state_nx = st_mem;
                    default:          state_nx = st_wb;
                endcase
            end
            st_mul:   state_nx = st_wb;
            st_mem:   state_nx = is_store ? st_wait : st_wb;
            st_wait:  if (wr_done) state_nx = st_wb;
            st_wb:    state_nx = st_fetch;
            default:  state_nx = st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_fetch;
            inst_pc <= '0;
        end else begin
            state <= state_nx;
            if (fetch_en)
                inst_pc <= pc;      // Captured before the step
        end
    end

    // ########################################
    // Stage strobes
    assign fetch_en    = (state == st_fetch) && run;
    assign rd_en       = (state == st_read);
    assign ex_en       = (state == st_exec);
    assign redirect_en = (state == st_wb) && res.taken;
    assign next_pc     = res.next_pc;

    // Data memory, read index also serves loads
    assign dm_idx    = res.idx;
    assign dm_wr_en  = (state == st_mem) && is_store;
    assign dm_wr_val = rt_val;

    // Write-through, launched with the local store
    assign wr_start = dm_wr_en;
    assign wr.addr  = `CPU_DATA_BASE + {{(`CPU_AXI_ADDR_W-9){1'b0}}, res.idx, 1'b0};
    assign wr.data  = res.st_data;

    // Writeback and retire record
    assign rf_wr_en  = (state == st_wb) && writes_rf;
    assign rf_wr_idx = is_load ? inst.rt : inst.rd;     // Load targets rt
    assign rf_wr_val = is_load ? mem_rd : res.value;

    assign retire_valid = (state == st_wb);
    assign retire.pc    = inst_pc;
    assign retire.we    = rf_wr_en;
    assign retire.rd    = rf_wr_idx;
    assign retire.value = rf_wr_val;

endmodule

`default_nettype wire

/* src/cpu_params.svh */
/*
 * Global sizes for the 16-bit multi-cycle core.
 * Both local memories are 256 words, so PC bits above 8 only wrap the fetch index.
 * External data word n lives at CPU_DATA_BASE + 2n.
 */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath
`define CPU_XLEN        16              // Register and data width
`define CPU_REG_CNT     16              // Architectural registers

// Local memories, in 16-bit words
`define CPU_IMEM_DEPTH  256
`define CPU_DMEM_DEPTH  256

// External write-through bus
`define CPU_AXI_ADDR_W  32
`define CPU_DATA_BASE   32'h0000_1000   // Byte address of data word 0

`endif

/* src/cpu_pkg.sv */
/*
 * Shared types of the core.
 * Opcodes 6 and 7 have no name and retire as no-ops.
 * Struct widths follow the sizes in cpu_params.svh.
 */
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        op_arith   = 3'd0,  // add / sub by func
        op_slt_mul = 3'd1,  // slt / mult by func
        op_load    = 3'd2,
        op_store   = 3'd3,
        op_beq     = 3'd4,
        op_jump    = 3'd5
    } opcode_e;

    // Field view of an instruction word
    typedef struct packed {
        opcode_e    opcode;  // [15:13]
        logic [3:0] rs;      // [12:9]
        logic [3:0] rt;      // [8:5]
        logic [3:0] rd;      // [4:1], upper part of imm
        logic       func;    // [0]
    } inst_t;

    typedef logic signed [`CPU_XLEN-1:0] word_t;

    // Program port entry
    typedef struct packed {
        logic       is_dmem;  // 1 data memory, 0 instruction memory
        logic [7:0] idx;      // Word index
        word_t      data;
    } prog_wr_t;

    typedef struct packed {
        word_t       value;    // ALU / slt / product
        logic [7:0]  idx;      // Data word index
        logic        taken;    // Branch taken or jump
        logic [11:0] next_pc;
        word_t       st_data;  // Store payload
    } exec_res_t;

    typedef struct packed {
        logic [`CPU_AXI_ADDR_W-1:0] addr;  // Byte address
        word_t                      data;
    } mem_wr_t;

    typedef struct packed {
        logic [11:0] pc;
        logic        we;
        logic [3:0]  rd;
        word_t       value;
    } retire_t;

endpackage

`default_nettype wire

/* src/cpu_top.sv */
/*
 * Core top, stage modules and the AXI4-Lite write master.
 * Program port writes are taken whenever prog_valid is high, so load only with run low.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       prog_valid,
    input  cpu_pkg::prog_wr_t          prog,
    output logic                       retire_valid,
    output cpu_pkg::retire_t           retire,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [`CPU_AXI_ADDR_W-1:0] awaddr,
    output logic                       wvalid,
    input  logic                       wready,
    output cpu_pkg::word_t             wdata,
    output logic [1:0]                 wstrb,
    input  logic                       bvalid,
    output logic                       bready
);
    import cpu_pkg::*;

    inst_t       inst;
    logic [11:0] pc, next_pc;
    exec_res_t   res;
    word_t       rs_val, rt_val, mem_rd, rf_wr_val, dm_wr_val;
    logic        fetch_en, rd_en, ex_en, redirect_en;
    logic        rf_wr_en, dm_wr_en, wr_start, wr_done;
    logic [3:0]  rf_wr_idx;
    logic [7:0]  dm_idx;
    mem_wr_t     wr;

    core_ctrl u_ctrl (
        .clk, .rst_n, .run, .inst, .pc, .res, .mem_rd, .rt_val,
        .fetch_en, .rd_en, .ex_en, .redirect_en, .next_pc,
        .rf_wr_en, .rf_wr_idx, .rf_wr_val,
        .dm_wr_en, .dm_idx, .dm_wr_val,
        .wr_start, .wr, .wr_done, .retire_valid, .retire
    );

    inst_fetch u_fetch (
        .clk, .rst_n, .prog_valid, .prog,
        .fetch_en, .redirect_en, .next_pc, .inst, .pc
    );

    reg_file u_rf (
        .clk, .rst_n, .rd_en,
        .rs_idx (inst.rs),
        .rt_idx (inst.rt),
        .rs_val, .rt_val,
        .wr_en  (rf_wr_en),
        .wr_idx (rf_wr_idx),
        .wr_val (rf_wr_val)
    );

    exec_unit u_exec (
        .clk, .rst_n, .ex_en, .inst, .pc, .rs_val, .rt_val, .res
    );

    data_mem u_dmem (
        .clk, .prog_valid, .prog,
        .wr_en  (dm_wr_en),
        .idx    (dm_idx),
        .wr_val (dm_wr_val),
        .rd_val (mem_rd)
    );

    axi_lite_writer u_axi_wr (
        .clk, .rst_n, .wr_start, .wr, .wr_done,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready
    );

endmodule

`default_nettype wire

/* src/data_mem.sv */
/*
 * Local data memory, registered read every cycle.
 * Preload writes win over store writes on the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module data_mem (
    input  logic               clk,
    input  logic               prog_valid,
    input  cpu_pkg::prog_wr_t  prog,
    input  logic               wr_en,
    input  logic [7:0]         idx,
    input  cpu_pkg::word_t     wr_val,
    output cpu_pkg::word_t     rd_val
);
    import cpu_pkg::*;

    word_t mem [`CPU_DMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (prog_valid && prog.is_dmem)
            mem[prog.idx] <= prog.data;     // Program port preload
        else if (wr_en)
            mem[idx] <= wr_val;             // Store
        rd_val <= mem[idx];
    end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
/*
 * Execute stage, result registered on ex_en.
 * Product is valid one cycle later than the other results.
 * pc input is the already stepped PC, i.e. instruction PC + 2.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_en,
    input  cpu_pkg::inst_t     inst,
    input  logic [11:0]        pc,
    input  cpu_pkg::word_t     rs_val,
    input  cpu_pkg::word_t     rt_val,
    output cpu_pkg::exec_res_t res
);
    import cpu_pkg::*;

    exec_res_t   res_d, res_q;
    logic [15:0] pp_lo;     // a * b[7:0]
    logic [7:0]  pp_hi;     // a[7:0] * b[15:8]
    word_t       mul_q;
    logic        is_mul;

    assign is_mul = (inst.opcode == op_slt_mul) && inst.func;

    always_comb begin
        logic signed [4:0] imm;
        word_t             addr;
        logic [11:0]       br_target;
        imm       = $signed({inst.rd, inst.func});
        addr      = rs_val + word_t'(imm);                    // Sign extended offset
        br_target = pc + {{6{imm[4]}}, imm, 1'b0};            // PC + 2 + 2*imm
        res_d         = '0;
        res_d.idx     = addr[7:0];
        res_d.st_data = rt_val;
        res_d.next_pc = pc;                                   // Fall through
        case (inst.opcode)
            op_arith:   res_d.value = inst.func ? rs_val - rt_val : rs_val + rt_val;
            op_slt_mul: res_d.value = (rs_val < rt_val) ? word_t'(1) : word_t'(0);
            op_beq: begin
                if (rs_val == rt_val) begin
                    res_d.taken   = 1'b1;
                    res_d.next_pc = br_target;
                end
            end
            op_jump: begin
                res_d.taken   = 1'b1;
                res_d.next_pc = {inst.rs[2:0], inst.rt, inst.rd, inst.func};
            end
            default: ;                                        // Load, store, no-op
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_q <= '0;
        else if (ex_en)
            res_q <= res_d;
    end

    // ########################################
    // Two-stage multiplier
    // Low 16 bits are the same for signed and unsigned operands
    always_ff @(posedge clk) begin
        if (ex_en) begin
            pp_lo <= rs_val[15:0] * {8'h00, rt_val[7:0]};     // Stage 1
            pp_hi <= rs_val[7:0] * rt_val[15:8];
        end
        mul_q <= pp_lo + {pp_hi, 8'h00};                      // Stage 2
    end

    always_comb begin
        res = res_q;
        if (is_mul)
            res.value = mul_q;  // Product replaces slt slot
    end

endmodule

`default_nettype wire

/* src/inst_fetch.sv */
/*
 * Instruction memory and program counter.
 * Program writes land whenever prog_valid is high, so drive them only while run is low.
 * PC steps by 2 on each fetch, a redirect overrides the step.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module inst_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               prog_valid,
    input  cpu_pkg::prog_wr_t  prog,
    input  logic               fetch_en,
    input  logic               redirect_en,
    input  logic [11:0]        next_pc,
    output cpu_pkg::inst_t     inst,
    output logic [11:0]        pc
);
    import cpu_pkg::*;

    inst_t imem [`CPU_IMEM_DEPTH];

    // Preload port and registered fetch
    always_ff @(posedge clk) begin
        if (prog_valid && !prog.is_dmem)
            imem[prog.idx] <= prog.data;
        if (fetch_en)
            inst <= imem[pc[8:1]];  // Byte PC to word index
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= '0;
        else if (redirect_en)
            pc <= next_pc;          // Taken branch or jump
        else if (fetch_en)
            pc <= pc + 12'd2;
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
/*
 * Sixteen signed registers, all cleared by reset.
 * Both read ports register on rd_en, one write port.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module reg_file (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rd_en,
    input  logic [3:0]      rs_idx,
    input  logic [3:0]      rt_idx,
    output cpu_pkg::word_t  rs_val,
    output cpu_pkg::word_t  rt_val,
    input  logic            wr_en,
    input  logic [3:0]      wr_idx,
    input  cpu_pkg::word_t  wr_val
);
    import cpu_pkg::*;

    word_t regs [`CPU_REG_CNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_CNT; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_val;
        end
    end

    // Operand latch for execute
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rs_val <= regs[rs_idx];
            rt_val <= regs[rt_idx];
        end
    end

endmodule

`default_nettype wire

/* test/tb_cpu.sv */
/*
 * Testbench for cpu_top.
 * Data and program words go in over the program port with run low, then every
 * retire record and every AXI write is compared with hand-computed tables.
 * The AXI slave model waits 0 to 5 random cycles before awready, wready and bvalid.
 * rd and value of a retire record are compared only when we is high.
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int RESET_CYC = 8;
    localparam int N_DATA    = 5;
    localparam int N_PROG    = 22;
    localparam int N_RET     = 18;
    localparam int N_WR      = 2;
    localparam int DRAIN_CYC = 16;     // Quiet window after run drops
    // Worst case per instruction plus AXI delay budget, plus load and reset
    localparam int TIMEOUT   = N_RET * (5 + 20) + N_DATA + N_PROG + RESET_CYC + DRAIN_CYC;

    logic                       clk;
    logic                       rst_n;
    logic                       run;
    logic                       prog_valid;
    prog_wr_t                   prog;
    logic                       retire_valid;
    retire_t                    retire;
    logic                       awvalid, wvalid, bready;
    logic                       awready = 1'b0;
    logic                       wready  = 1'b0;
    logic                       bvalid  = 1'b0;
    logic [`CPU_AXI_ADDR_W-1:0] awaddr;
    word_t                      wdata;
    logic [1:0]                 wstrb;

    prog_wr_t data_tab [N_DATA];       // Data memory preload
    prog_wr_t prog_tab [N_PROG];       // Instruction memory image
    retire_t  exp_ret  [N_RET];
    mem_wr_t  exp_wr   [N_WR];

    int      err_retire = 0;
    int      err_write  = 0;
    int      err_misc   = 0;
    int      ret_idx    = 0;
    int      n_wr       = 0;
    int      cycles     = 0;
    integer  seed       = 32'hae3c_52ac;
    int      aw_gap     = -1;          // -1 means no gap drawn yet
    int      w_gap      = -1;
    int      b_gap      = -1;
    logic    aw_seen    = 1'b0;
    logic    w_seen     = 1'b0;
    logic    b_pend     = 1'b0;
    mem_wr_t got_wr;

    cpu_top DUT (
        .clk, .rst_n, .run, .prog_valid, .prog, .retire_valid, .retire,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;         // 8 ns period
    end

    // ########################################
    // Instruction encoders
    function automatic logic [15:0] reg_word(input opcode_e op, input logic [3:0] rs,
                                             input logic [3:0] rt, input logic [3:0] rd,
                                             input logic func);
        return {op, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] imm_word(input opcode_e op, input logic [3:0] rs,
                                             input logic [3:0] rt,
                                             input logic signed [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] jump_word(input logic [11:0] target);
        return {op_jump, 1'b0, target};    // Bit 12 unused
    endfunction

    function automatic retire_t retire_rec(input logic [11:0] pc, input logic we,
                                           input logic [3:0] rd, input logic [15:0] value);
        return '{pc: pc, we: we, rd: rd, value: value};
    endfunction

    // ########################################
    // Stimulus and expected tables
    task automatic build_tables;
        logic [15:0] filler;
        filler = reg_word(op_arith, 4'd1, 4'd1, 4'd13, 1'b0);   // Must never retire
        data_tab[0] = '{1'b1, 8'h03, 16'h7ff0};
        data_tab[1] = '{1'b1, 8'h04, 16'h0025};
        data_tab[2] = '{1'b1, 8'h05, 16'hfffd};
        data_tab[3] = '{1'b1, 8'h23, 16'h1234};   // Overwritten by first store
        data_tab[4] = '{1'b1, 8'hf5, 16'h5678};   // Overwritten by second store
        prog_tab[0]  = '{1'b0, 8'd0,  imm_word(op_load, 4'd0, 4'd1, 5'sd3)};
        prog_tab[1]  = '{1'b0, 8'd1,  imm_word(op_load, 4'd0, 4'd2, 5'sd4)};
        prog_tab[2]  = '{1'b0, 8'd2,  imm_word(op_load, 4'd0, 4'd3, 5'sd5)};
        prog_tab[3]  = '{1'b0, 8'd3,  reg_word(op_arith, 4'd1, 4'd2, 4'd4, 1'b0)};   // add
        prog_tab[4]  = '{1'b0, 8'd4,  reg_word(op_arith, 4'd3, 4'd1, 4'd5, 1'b1)};   // sub
        prog_tab[5]  = '{1'b0, 8'd5,  reg_word(op_slt_mul, 4'd3, 4'd2, 4'd6, 1'b0)};
        prog_tab[6]  = '{1'b0, 8'd6,  reg_word(op_slt_mul, 4'd2, 4'd3, 4'd7, 1'b0)};
        prog_tab[7]  = '{1'b0, 8'd7,  reg_word(op_slt_mul, 4'd3, 4'd2, 4'd8, 1'b1)}; // mul
        prog_tab[8]  = '{1'b0, 8'd8,  reg_word(op_slt_mul, 4'd1, 4'd3, 4'd9, 1'b1)};
        prog_tab[9]  = '{1'b0, 8'd9,  imm_word(op_store, 4'd2, 4'd4, -5'sd2)};
        prog_tab[10] = '{1'b0, 8'd10, imm_word(op_store, 4'd1, 4'd5, 5'sd5)};
        prog_tab[11] = '{1'b0, 8'd11, imm_word(op_load, 4'd2, 4'd10, -5'sd2)};
        prog_tab[12] = '{1'b0, 8'd12, imm_word(op_load, 4'd1, 4'd11, 5'sd5)};
        prog_tab[13] = '{1'b0, 8'd13, imm_word(op_beq, 4'd7, 4'd0, 5'sd3)};      // Taken
        prog_tab[14] = '{1'b0, 8'd14, filler};
        prog_tab[15] = '{1'b0, 8'd15, filler};
        prog_tab[16] = '{1'b0, 8'd16, filler};
        prog_tab[17] = '{1'b0, 8'd17, imm_word(op_beq, 4'd1, 4'd2, -5'sd8)};     // Not taken
        prog_tab[18] = '{1'b0, 8'd18, jump_word(12'h040)};
        prog_tab[19] = '{1'b0, 8'd19, filler};
        prog_tab[20] = '{1'b0, 8'd32, reg_word(op_arith, 4'd10, 4'd11, 4'd12, 1'b0)};
        prog_tab[21] = '{1'b0, 8'd33, jump_word(12'h042)};   // Park on itself

        exp_ret[0]  = retire_rec(12'h000, 1'b1, 4'h1, 16'h7ff0);
        exp_ret[1]  = retire_rec(12'h002, 1'b1, 4'h2, 16'h0025);
        exp_ret[2]  = retire_rec(12'h004, 1'b1, 4'h3, 16'hfffd);
        exp_ret[3]  = retire_rec(12'h006, 1'b1, 4'h4, 16'h8015);   // 0x7ff0 + 0x25 wraps
        exp_ret[4]  = retire_rec(12'h008, 1'b1, 4'h5, 16'h800d);   // -3 - 0x7ff0
        exp_ret[5]  = retire_rec(12'h00a, 1'b1, 4'h6, 16'h0001);   // -3 < 37
        exp_ret[6]  = retire_rec(12'h00c, 1'b1, 4'h7, 16'h0000);
        exp_ret[7]  = retire_rec(12'h00e, 1'b1, 4'h8, 16'hff91);   // -3 * 37 = -111
        exp_ret[8]  = retire_rec(12'h010, 1'b1, 4'h9, 16'h8030);   // Low half of -98256
        exp_ret[9]  = retire_rec(12'h012, 1'b0, 4'h0, 16'h0000);
        exp_ret[10] = retire_rec(12'h014, 1'b0, 4'h0, 16'h0000);
        exp_ret[11] = retire_rec(12'h016, 1'b1, 4'ha, 16'h8015);
        exp_ret[12] = retire_rec(12'h018, 1'b1, 4'hb, 16'h800d);
        exp_ret[13] = retire_rec(12'h01a, 1'b0, 4'h0, 16'h0000);   // To 0x1a + 2 + 6
        exp_ret[14] = retire_rec(12'h022, 1'b0, 4'h0, 16'h0000);
        exp_ret[15] = retire_rec(12'h024, 1'b0, 4'h0, 16'h0000);
        exp_ret[16] = retire_rec(12'h040, 1'b1, 4'hc, 16'h0022);
        exp_ret[17] = retire_rec(12'h042, 1'b0, 4'h0, 16'h0000);

        // Word index 0x25 - 2 and (0x7ff0 + 5) truncated to 8 bits
        exp_wr[0] = '{`CPU_DATA_BASE + 32'h23 * 2, 16'h8015};
        exp_wr[1] = '{`CPU_DATA_BASE + 32'hf5 * 2, 16'h800d};
    endtask

    // ########################################
    // Compare tasks
    task automatic check_retire(input retire_t got, input retire_t want);
        if (got.pc !== want.pc || got.we !== want.we ||
            (want.we && (got.rd !== want.rd || got.value !== want.value))) begin
            $display("ERROR retire: pc=%h we=%h rd=%h value=%h, expected pc=%h we=%h rd=%h value=%h",
                     got.pc, got.we, got.rd, got.value,
                     want.pc, want.we, want.rd, want.value);
            err_retire++;
        end
    endtask

    task automatic check_write(input mem_wr_t got, input mem_wr_t want);
        if (got.addr !== want.addr || got.data !== want.data) begin
            $display("ERROR write: awaddr=%h wdata=%h, expected awaddr=%h wdata=%h",
                     got.addr, got.data, want.addr, want.data);
            err_write++;
        end
    endtask

    // Every beat carries a full 16-bit word
    task automatic check_wstrb(input logic [1:0] got);
        if (got !== 2'b11) begin
            $display("ERROR wstrb: wstrb=%h, expected wstrb=%h", got, 2'b11);
            err_write++;
        end
    endtask

    task automatic load_word(input prog_wr_t entry);
        @(posedge clk);
        prog_valid <= 1'b1;
        prog       <= entry;
        if (retire_valid || awvalid || wvalid || bready) begin
            $display("Core became active during program load with run low");
            err_misc++;
        end
    endtask

    // ########################################
    // AXI4-Lite slave with random ready and response gaps
    always @(posedge clk) begin
        if (awvalid && awready) begin
            awready     <= 1'b0;
            got_wr.addr = awaddr;
            aw_seen     = 1'b1;
            aw_gap      = -1;
        end else if (awvalid) begin
            if (aw_gap < 0)
                aw_gap = $unsigned($random(seed)) % 6;
            if (aw_gap == 0)
                awready <= 1'b1;
            else
                aw_gap = aw_gap - 1;
        end

        if (wvalid && wready) begin
            wready      <= 1'b0;
            got_wr.data = wdata;
            check_wstrb(wstrb);
            w_seen      = 1'b1;
            w_gap       = -1;
        end else if (wvalid) begin
            if (w_gap < 0)
                w_gap = $unsigned($random(seed)) % 6;
            if (w_gap == 0)
                wready <= 1'b1;
            else
                w_gap = w_gap - 1;
        end

        // Both channels done, so one complete write
        if (aw_seen && w_seen) begin
            if (n_wr >= N_WR) begin
                $display("Unexpected extra AXI write to address %h", got_wr.addr);
                err_write++;
            end else begin
                check_write(got_wr, exp_wr[n_wr]);
            end
            n_wr++;
            aw_seen = 1'b0;
            w_seen  = 1'b0;
            b_pend  = 1'b1;
        end

        if (bvalid && bready) begin
            bvalid <= 1'b0;
            b_gap  = -1;
        end else if (b_pend && !bvalid) begin
            if (b_gap < 0)
                b_gap = $unsigned($random(seed)) % 6;
            if (b_gap == 0) begin
                bvalid <= 1'b1;
                b_pend = 1'b0;
            end else begin
                b_gap = b_gap - 1;
            end
        end
    end

    // ########################################
    // Main sequence
    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        prog_valid = 1'b0;
        prog       = '0;
        build_tables();
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (awvalid || wvalid || bready || retire_valid) begin
            $display("Outputs not idle after reset: awvalid=%b wvalid=%b bready=%b retire_valid=%b",
                     awvalid, wvalid, bready, retire_valid);
            err_misc++;
        end

        for (int i = 0; i < N_DATA; i++)
            load_word(data_tab[i]);
        for (int i = 0; i < N_PROG; i++)
            load_word(prog_tab[i]);
        @(posedge clk);
        prog_valid <= 1'b0;
        run        <= 1'b1;

        // One table entry per retire pulse
        while (ret_idx < N_RET) begin
            @(posedge clk);
            if (retire_valid) begin
                check_retire(retire, exp_ret[ret_idx]);
                ret_idx++;
                if (ret_idx == N_RET)
                    run <= 1'b0;     // Stop before the parked jump refetches
            end
        end

        repeat (DRAIN_CYC) begin
            @(posedge clk);
            if (retire_valid) begin
                $display("Retire pulse at pc %h while run is low", retire.pc);
                err_misc++;
            end
        end
        if (n_wr != N_WR) begin
            $display("Saw %0d AXI writes but expected %0d", n_wr, N_WR);
            err_misc++;
        end

        $display("Errors: retire %0d, write %0d, other %0d", err_retire, err_write, err_misc);
        if (err_retire + err_write + err_misc == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d retires seen", cycles, ret_idx, N_RET);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
